// ==== all.f ====
hdl/wht_mem_pkg.sv
hdl/wht_ram_bank.sv
hdl/wht_sink_ctrl.sv
hdl/wht_stage_rd.sv
hdl/wht_butterfly_wb.sv
hdl/wht_source_ctrl.sv
hdl/wht_mem_top.sv
verification/wht_mem_tb.sv

// ==== hdl/wht_butterfly_wb.sv ====
`timescale 1ns/1ns

module wht_butterfly_wb #(
	parameter int DATA_W    = 16,
	parameter int LOG_N_MAX = 6
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  wht_mem_pkg::mem_state_e            state,
	input  logic [2:0]                         size,
	input  logic                               pair_valid,
	input  logic                               lo_bank,
	input  logic [LOG_N_MAX-2:0]               lo_row,
	input  logic [LOG_N_MAX-2:0]               hi_row,
	input  logic signed [DATA_W+LOG_N_MAX-1:0] rd_data_0,
	input  logic signed [DATA_W+LOG_N_MAX-1:0] rd_data_1,
	output logic [1:0]                         wr_en,
	output logic [LOG_N_MAX-2:0]               wr_row_0,
	output logic [LOG_N_MAX-2:0]               wr_row_1,
	output logic signed [DATA_W+LOG_N_MAX-1:0] wr_data_0,
	output logic signed [DATA_W+LOG_N_MAX-1:0] wr_data_1,
	output logic                               wr_end
);
	import wht_mem_pkg::*;

	localparam int RW = LOG_N_MAX - 1;
	localparam int WW = DATA_W + LOG_N_MAX;

	logic                 pv_q;
	logic                 lo_bank_q;
	logic [RW-1:0]        lo_row_q;
	logic [RW-1:0]        hi_row_q;
	logic [RW-1:0]        cnt;
	logic [RW-1:0]        last_cnt;
	logic signed [WW-1:0] lo_word;
	logic signed [WW-1:0] hi_word;

	assign last_cnt = RW'((32'd1 << (size - 3'd1)) - 32'd1);

	// Bank words sorted into lower and upper point
	assign lo_word = lo_bank_q ? rd_data_1 : rd_data_0;
	assign hi_word = lo_bank_q ? rd_data_0 : rd_data_1;

	// Tags one cycle late to meet the bank read data
	always_ff @(posedge clk) begin
		lo_bank_q <= lo_bank;
		lo_row_q  <= lo_row;
		hi_row_q  <= hi_row;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pv_q   <= 1'b0;
			cnt    <= '0;
			wr_en  <= '0;
			wr_end <= 1'b0;
		end else begin
			pv_q   <= pair_valid;
			wr_en  <= '0;
			wr_end <= 1'b0;
			if (state == IDLE) begin
				// Dropped frame leaves no stale count
				cnt <= '0;
			end else if (pv_q) begin
				wr_en <= 2'b11;
				cnt   <= cnt + 1'b1;
				if (cnt == last_cnt) begin
					wr_end <= 1'b1;
					cnt    <= '0;
				end
			end
		end
	end

	// Sum back to the lower address, difference to the partner
	always_ff @(posedge clk) begin
		if (pv_q) begin
			if (lo_bank_q) begin
				wr_data_1 <= lo_word + hi_word;
				wr_row_1  <= lo_row_q;
				wr_data_0 <= lo_word - hi_word;
				wr_row_0  <= hi_row_q;
			end else begin
				wr_data_0 <= lo_word + hi_word;
				wr_row_0  <= lo_row_q;
				wr_data_1 <= lo_word - hi_word;
				wr_row_1  <= hi_row_q;
			end
		end
	end

endmodule

// ==== hdl/wht_mem_pkg.sv ====
package wht_mem_pkg;

	// ----------------------------------------------------------------------
	// Controller state
	// ----------------------------------------------------------------------
	// Frame flow is IDLE, SINK, then RD and WAIT_WR_END once per stage,
	// then SOURCE and back to IDLE
	typedef enum logic [2:0] {
		// Waiting for start of packet
		IDLE        = 3'd0,
		// Frame being written into the banks
		SINK        = 3'd1,
		// Butterfly pairs read for the current stage
		RD          = 3'd2,
		// Draining the write-back pipeline
		WAIT_WR_END = 3'd3,
		// Result read out in natural order
		SOURCE      = 3'd4
	} mem_state_e;

	// ----------------------------------------------------------------------
	// Bank layout
	// ----------------------------------------------------------------------
	// Parity of the address bits picks the bank, so the two points of
	// any butterfly always land in different banks
	localparam int NUM_BANKS = 2;

endpackage

// ==== hdl/wht_mem_top.sv ====
`timescale 1ns/1ns

module wht_mem_top #(
	parameter int DATA_W       = 16,
	parameter int LOG_N_MAX    = 6,
	parameter int SINK_TIMEOUT = 32
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               in_valid,
	input  logic                               in_sop,
	input  logic [2:0]                         in_size,
	input  logic signed [DATA_W-1:0]           in_data,
	output logic                               sink_ready,
	output logic                               out_valid,
	output logic                               out_sop,
	output logic                               out_eop,
	output logic signed [DATA_W+LOG_N_MAX-1:0] out_data,
	output wht_mem_pkg::mem_state_e            state
);
	import wht_mem_pkg::*;

	localparam int RW = LOG_N_MAX - 1;
	localparam int WW = DATA_W + LOG_N_MAX;

	mem_state_e state_q;
	logic [2:0] size;
	logic [2:0] cnt_stage;
	logic       sop_take;
	logic       sink_end;
	logic       over_time;
	logic       rd_end;
	logic       wr_end;
	logic       source_end;

	// Sink side writes
	logic [1:0]           sk_wr_en;
	logic [RW-1:0]        sk_wr_row;
	logic signed [WW-1:0] sk_wr_data;

	// Stage reads and pair tags
	logic [1:0]    sr_rd_en;
	logic [RW-1:0] sr_rd_row [NUM_BANKS];
	logic          pair_valid;
	logic          lo_bank;
	logic [RW-1:0] lo_row;
	logic [RW-1:0] hi_row;

	// Butterfly write-back
	logic [1:0]           bf_wr_en;
	logic [RW-1:0]        bf_wr_row [NUM_BANKS];
	logic signed [WW-1:0] bf_wr_data [NUM_BANKS];

	// Source reads
	logic [NUM_BANKS-1:0] so_rd_en;
	logic [RW-1:0]        so_rd_row;

	// Bank ports after the multiplexers
	logic                 bank_wr_en [NUM_BANKS];
	logic [RW-1:0]        bank_wr_row [NUM_BANKS];
	logic signed [WW-1:0] bank_wr_data [NUM_BANKS];
	logic                 bank_rd_en [NUM_BANKS];
	logic [RW-1:0]        bank_rd_row [NUM_BANKS];
	logic signed [WW-1:0] bank_rd_data [NUM_BANKS];

	assign sop_take = (state == IDLE) && sink_ready && in_valid && in_sop;

	// ----------------------------------------------------------------------
	// Controller FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			state_q    <= IDLE;
			sink_ready <= 1'b0;
		end else begin
			state_q    <= state;
			sink_ready <= (state == IDLE);
			case (state)
				IDLE: begin
					if (sop_take) state <= SINK;
				end
				SINK: begin
					// Full frame wins over a late timeout
					if (sink_end) state <= RD;
					else if (over_time) state <= IDLE;
				end
				RD: begin
					if (rd_end) state <= WAIT_WR_END;
				end
				WAIT_WR_END: begin
					if (wr_end) state <= (cnt_stage == size - 3'd1) ? SOURCE : RD;
				end
				SOURCE: begin
					if (source_end) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Frame size and stage count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			size      <= '0;
			cnt_stage <= '0;
		end else begin
			if (sop_take) size <= in_size;
			if (state == IDLE) begin
				cnt_stage <= '0;
			end else if ((state == RD) && (state_q == WAIT_WR_END)) begin
				// Next stage on re-entry into RD
				cnt_stage <= cnt_stage + 3'd1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Banks with their write and read multiplexers
	// ----------------------------------------------------------------------
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		// Registered write mux, sink path only during SINK
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				bank_wr_en[b] <= 1'b0;
			end else begin
				bank_wr_en[b] <= (state == SINK) ? sk_wr_en[b] : bf_wr_en[b];
			end
		end

		always_ff @(posedge clk) begin
			bank_wr_row[b]  <= (state == SINK) ? sk_wr_row : bf_wr_row[b];
			bank_wr_data[b] <= (state == SINK) ? sk_wr_data : bf_wr_data[b];
		end

		// Read mux, stage reader in RD, source reader otherwise
		assign bank_rd_en[b]  = (state == RD) ? sr_rd_en[b] : so_rd_en[b];
		assign bank_rd_row[b] = (state == RD) ? sr_rd_row[b] : so_rd_row;

		wht_ram_bank #(
			.DATA_W    (DATA_W),
			.LOG_N_MAX (LOG_N_MAX)
		) u_bank (
			.clk     (clk),
			.wr_en   (bank_wr_en[b]),
			.wr_row  (bank_wr_row[b]),
			.wr_data (bank_wr_data[b]),
			.rd_en   (bank_rd_en[b]),
			.rd_row  (bank_rd_row[b]),
			.rd_data (bank_rd_data[b])
		);
	end

	// ----------------------------------------------------------------------
	// Sequencers
	// ----------------------------------------------------------------------
	wht_sink_ctrl #(
		.DATA_W       (DATA_W),
		.LOG_N_MAX    (LOG_N_MAX),
		.SINK_TIMEOUT (SINK_TIMEOUT)
	) u_sink (
		.clk       (clk),
		.rst_n     (rst_n),
		.state     (state),
		.size      (size),
		.in_valid  (in_valid),
		.in_sop    (in_sop),
		.in_data   (in_data),
		.wr_en     (sk_wr_en),
		.wr_row    (sk_wr_row),
		.wr_data   (sk_wr_data),
		.sink_end  (sink_end),
		.over_time (over_time)
	);

	wht_stage_rd #(
		.LOG_N_MAX (LOG_N_MAX)
	) u_stage_rd (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.size       (size),
		.cnt_stage  (cnt_stage),
		.rd_en      (sr_rd_en),
		.rd_row_0   (sr_rd_row[0]),
		.rd_row_1   (sr_rd_row[1]),
		.pair_valid (pair_valid),
		.lo_bank    (lo_bank),
		.lo_row     (lo_row),
		.hi_row     (hi_row),
		.rd_end     (rd_end)
	);

	wht_butterfly_wb #(
		.DATA_W    (DATA_W),
		.LOG_N_MAX (LOG_N_MAX)
	) u_butterfly (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.size       (size),
		.pair_valid (pair_valid),
		.lo_bank    (lo_bank),
		.lo_row     (lo_row),
		.hi_row     (hi_row),
		.rd_data_0  (bank_rd_data[0]),
		.rd_data_1  (bank_rd_data[1]),
		.wr_en      (bf_wr_en),
		.wr_row_0   (bf_wr_row[0]),
		.wr_row_1   (bf_wr_row[1]),
		.wr_data_0  (bf_wr_data[0]),
		.wr_data_1  (bf_wr_data[1]),
		.wr_end     (wr_end)
	);

	wht_source_ctrl #(
		.DATA_W    (DATA_W),
		.LOG_N_MAX (LOG_N_MAX)
	) u_source (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.size       (size),
		.rd_data_0  (bank_rd_data[0]),
		.rd_data_1  (bank_rd_data[1]),
		.rd_en      (so_rd_en),
		.rd_row     (so_rd_row),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_data   (out_data),
		.source_end (source_end)
	);

endmodule

// ==== hdl/wht_ram_bank.sv ====
`timescale 1ns/1ns

module wht_ram_bank #(
	parameter int DATA_W    = 16,
	parameter int LOG_N_MAX = 6
) (
	input  logic                               clk,
	input  logic                               wr_en,
	input  logic [LOG_N_MAX-2:0]               wr_row,
	input  logic signed [DATA_W+LOG_N_MAX-1:0] wr_data,
	input  logic                               rd_en,
	input  logic [LOG_N_MAX-2:0]               rd_row,
	output logic signed [DATA_W+LOG_N_MAX-1:0] rd_data
);

	// Half a frame per bank
	localparam int DEPTH = 2 ** (LOG_N_MAX - 1);
	localparam int WW    = DATA_W + LOG_N_MAX;

	logic signed [WW-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_row] <= wr_data;
		end
	end

	// Registered read, output holds while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_row];
		end
	end

endmodule

// ==== hdl/wht_sink_ctrl.sv ====
`timescale 1ns/1ns

module wht_sink_ctrl #(
	parameter int DATA_W       = 16,
	parameter int LOG_N_MAX    = 6,
	parameter int SINK_TIMEOUT = 32
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  wht_mem_pkg::mem_state_e            state,
	input  logic [2:0]                         size,
	input  logic                               in_valid,
	input  logic                               in_sop,
	input  logic signed [DATA_W-1:0]           in_data,
	output logic [1:0]                         wr_en,
	output logic [LOG_N_MAX-2:0]               wr_row,
	output logic signed [DATA_W+LOG_N_MAX-1:0] wr_data,
	output logic                               sink_end,
	output logic                               over_time
);
	import wht_mem_pkg::*;

	localparam int AW = LOG_N_MAX;
	localparam int WW = DATA_W + LOG_N_MAX;
	localparam int TW = $clog2(SINK_TIMEOUT + 1);

	logic          ready_q;
	logic [AW-1:0] cnt;
	logic [AW-1:0] addr;
	logic [AW-1:0] last_addr;
	logic [TW-1:0] gap;
	logic          take_sop;
	logic          take;

	// Start of packet only while the ready flag is shown
	assign take_sop  = (state == IDLE) && ready_q && in_valid && in_sop;
	// No more samples once the last one has been taken
	assign take      = take_sop || ((state == SINK) && in_valid && !sink_end);
	assign addr      = take_sop ? '0 : cnt;
	assign last_addr = AW'((32'd1 << size) - 32'd1);

	// ----------------------------------------------------------------------
	// Sample counter and bank write enables
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ready_q  <= 1'b0;
			cnt      <= '0;
			wr_en    <= '0;
			sink_end <= 1'b0;
		end else begin
			// Same timing as sink_ready at the top
			ready_q  <= (state == IDLE);
			wr_en    <= '0;
			sink_end <= 1'b0;
			if (take) begin
				// Parity bank only
				wr_en[^addr] <= 1'b1;
				cnt          <= addr + 1'b1;
				sink_end     <= (state == SINK) && (addr == last_addr);
			end
		end
	end

	// Row drops the lowest address bit, sample sign-extended to word width
	always_ff @(posedge clk) begin
		if (take) begin
			wr_row  <= addr[AW-1:1];
			wr_data <= WW'(in_data);
		end
	end

	// ----------------------------------------------------------------------
	// Gap counter for the sink timeout
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gap       <= '0;
			over_time <= 1'b0;
		end else begin
			if ((state != SINK) || in_valid) begin
				gap <= '0;
			end else begin
				gap <= gap + 1'b1;
			end
			over_time <= (state == SINK) && !in_valid && (gap == TW'(SINK_TIMEOUT - 1));
		end
	end

endmodule

// ==== hdl/wht_source_ctrl.sv ====
`timescale 1ns/1ns

module wht_source_ctrl #(
	parameter int DATA_W    = 16,
	parameter int LOG_N_MAX = 6
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  wht_mem_pkg::mem_state_e             state,
	input  logic [2:0]                          size,
	input  logic signed [DATA_W+LOG_N_MAX-1:0]  rd_data_0,
	input  logic signed [DATA_W+LOG_N_MAX-1:0]  rd_data_1,
	output logic [wht_mem_pkg::NUM_BANKS-1:0]   rd_en,
	output logic [LOG_N_MAX-2:0]                rd_row,
	output logic                                out_valid,
	output logic                                out_sop,
	output logic                                out_eop,
	output logic signed [DATA_W+LOG_N_MAX-1:0]  out_data,
	output logic                                source_end
);
	import wht_mem_pkg::*;

	localparam int AW = LOG_N_MAX;

	logic [AW-1:0] addr;
	logic [AW-1:0] last_addr;
	logic          done;
	logic          first_q;
	logic          issue;
	logic          vld_d;
	logic          sel_d;
	logic          sop_d;
	logic          eop_d;

	assign last_addr = AW'((32'd1 << size) - 32'd1);
	assign issue     = (state == SOURCE) && !done;

	// ----------------------------------------------------------------------
	// Address walk, one read per cycle
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			addr       <= '0;
			done       <= 1'b0;
			rd_en      <= '0;
			first_q    <= 1'b0;
			source_end <= 1'b0;
			vld_d      <= 1'b0;
			sop_d      <= 1'b0;
			eop_d      <= 1'b0;
			out_valid  <= 1'b0;
			out_sop    <= 1'b0;
			out_eop    <= 1'b0;
		end else begin
			rd_en      <= '0;
			first_q    <= 1'b0;
			source_end <= 1'b0;
			if (state != SOURCE) begin
				addr <= '0;
				done <= 1'b0;
			end else if (issue) begin
				// Only the parity bank
				rd_en[^addr] <= 1'b1;
				first_q      <= (addr == '0);
				addr         <= addr + 1'b1;
				if (addr == last_addr) begin
					source_end <= 1'b1;
					done       <= 1'b1;
				end
			end
			// Flags ride beside the bank read
			vld_d     <= |rd_en;
			sop_d     <= first_q;
			eop_d     <= source_end;
			// Output stage
			out_valid <= vld_d;
			out_sop   <= sop_d;
			out_eop   <= eop_d;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			rd_row <= addr[AW-1:1];
		end
	end

	// Pick the bank that was read last cycle
	always_ff @(posedge clk) begin
		sel_d <= rd_en[1];
		if (vld_d) begin
			out_data <= sel_d ? rd_data_1 : rd_data_0;
		end
	end

endmodule

// ==== hdl/wht_stage_rd.sv ====
`timescale 1ns/1ns

module wht_stage_rd #(
	parameter int LOG_N_MAX = 6
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  wht_mem_pkg::mem_state_e state,
	input  logic [2:0]              size,
	input  logic [2:0]              cnt_stage,
	output logic [1:0]              rd_en,
	output logic [LOG_N_MAX-2:0]    rd_row_0,
	output logic [LOG_N_MAX-2:0]    rd_row_1,
	output logic                    pair_valid,
	output logic                    lo_bank,
	output logic [LOG_N_MAX-2:0]    lo_row,
	output logic [LOG_N_MAX-2:0]    hi_row,
	output logic                    rd_end
);
	import wht_mem_pkg::*;

	localparam int AW = LOG_N_MAX;
	localparam int RW = LOG_N_MAX - 1;

	logic [RW-1:0] idx;
	logic [RW-1:0] last_idx;
	logic          armed;
	logic          done;
	logic          issue;
	logic [AW-1:0] pair;
	logic [AW-1:0] low_mask;
	logic [AW-1:0] lo_addr;
	logic [AW-1:0] hi_addr;
	logic          lo_par;

	// Half a frame of pairs per stage
	assign last_idx = RW'((32'd1 << (size - 3'd1)) - 32'd1);
	// First RD cycle skipped so the stage count has settled
	assign issue    = (state == RD) && armed && !done;

	// ----------------------------------------------------------------------
	// Pair addressing
	// ----------------------------------------------------------------------
	// Zero inserted at bit cnt_stage gives the lower point
	assign pair     = AW'(idx);
	assign low_mask = (AW'(1) << cnt_stage) - AW'(1);
	assign lo_addr  = ((pair & ~low_mask) << 1) | (pair & low_mask);
	// Partner has that bit set
	assign hi_addr  = lo_addr | (AW'(1) << cnt_stage);
	assign lo_par   = ^lo_addr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx        <= '0;
			armed      <= 1'b0;
			done       <= 1'b0;
			rd_en      <= '0;
			pair_valid <= 1'b0;
			rd_end     <= 1'b0;
		end else begin
			rd_en      <= '0;
			pair_valid <= 1'b0;
			rd_end     <= 1'b0;
			if (state != RD) begin
				// Restart on every entry into RD
				idx   <= '0;
				armed <= 1'b0;
				done  <= 1'b0;
			end else begin
				armed <= 1'b1;
				if (issue) begin
					// Both banks read every cycle
					rd_en      <= 2'b11;
					pair_valid <= 1'b1;
					idx        <= idx + 1'b1;
					if (idx == last_idx) begin
						rd_end <= 1'b1;
						done   <= 1'b1;
					end
				end
			end
		end
	end

	// Rows to their banks, tags for the write-back side
	always_ff @(posedge clk) begin
		if (issue) begin
			rd_row_0 <= lo_par ? hi_addr[AW-1:1] : lo_addr[AW-1:1];
			rd_row_1 <= lo_par ? lo_addr[AW-1:1] : hi_addr[AW-1:1];
			lo_bank  <= lo_par;
			lo_row   <= lo_addr[AW-1:1];
			hi_row   <= hi_addr[AW-1:1];
		end
	end

endmodule

// ==== verification/wht_mem_tb.sv ====
`timescale 1ns/1ns

module wht_mem_tb;
	import wht_mem_pkg::*;

	localparam int DATA_W       = 16;
	localparam int LOG_N_MAX    = 6;
	localparam int SINK_TIMEOUT = 32;
	localparam int WW           = DATA_W + LOG_N_MAX;
	localparam int N_MAX        = 1 << LOG_N_MAX;
	localparam int CLK_PERIOD   = 4;
	// Longest idle run inside a frame, kept below the sink timeout
	localparam int MAX_GAP      = 20;
	localparam int NUM_B2B      = 10;
	localparam int NUM_FRAMES   = LOG_N_MAX + 2 + NUM_B2B;
	// Worst case per frame: gappy sink, all stages, source, timeout
	localparam longint FRAME_CYCLES = N_MAX * (MAX_GAP + 2)
		+ LOG_N_MAX * (N_MAX / 2 + 8) + N_MAX + SINK_TIMEOUT + 20;
	localparam longint WATCHDOG_NS  = 2 * NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD + 1000;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_sop;
	logic [2:0]           in_size;
	logic signed [DATA_W-1:0] in_data;
	logic                 sink_ready;
	logic                 out_valid;
	logic                 out_sop;
	logic                 out_eop;
	logic signed [WW-1:0] out_data;
	mem_state_e           state;

	// Model output, one entry per expected word
	longint      exp_data [$];
	bit          exp_sop [$];
	bit          exp_eop [$];
	int          frame_buf [N_MAX];
	logic [31:0] rng_state = 32'd34352;
	int          errors = 0;
	int          words_seen = 0;
	int          words_before;
	int          b2b_size;
	bit          in_burst = 1'b0;

	wht_mem_top #(
		.DATA_W       (DATA_W),
		.LOG_N_MAX    (LOG_N_MAX),
		.SINK_TIMEOUT (SINK_TIMEOUT)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_size    (in_size),
		.in_data    (in_data),
		.sink_ready (sink_ready),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_data   (out_data),
		.state      (state)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic stop_on_failure();
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input longint actual, input longint expected, input string what);
		if (actual != expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
			stop_on_failure();
		end
	endtask

	// 32-bit xorshift
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Full-scale samples, extremes now and then
	function automatic int random_sample();
		logic [31:0] r;
		r = next_random();
		case (r[2:0])
			3'd0: return -32768;
			3'd1: return 32767;
			default: return int'($signed(r[31:16]));
		endcase
	endfunction

	// Hadamard reference, sign from parity of shared bits of k and m
	function automatic void push_expected(input int sz);
		int n;
		longint acc;
		logic [LOG_N_MAX-1:0] kb;
		logic [LOG_N_MAX-1:0] mb;
		n = 1 << sz;
		for (int k = 0; k < n; k++) begin
			acc = 0;
			kb  = k[LOG_N_MAX-1:0];
			for (int m = 0; m < n; m++) begin
				mb = m[LOG_N_MAX-1:0];
				if (^(kb & mb)) acc -= frame_buf[m];
				else acc += frame_buf[m];
			end
			exp_data.push_back(acc);
			exp_sop.push_back(k == 0);
			exp_eop.push_back(k == n - 1);
		end
	endfunction

	// Idle until the DUT takes a new packet, stray valids while busy
	task automatic wait_for_ready();
		logic [31:0] r;
		while (!((sink_ready === 1'b1) && (state == IDLE))) begin
			r = next_random();
			if (!sink_ready && (state != SINK) && (r[1:0] == 2'b00)) begin
				in_valid = 1'b1;
				in_sop   = r[2];
				in_size  = r[5:3];
				in_data  = r[31:16];
			end else begin
				in_valid = 1'b0;
				in_sop   = 1'b0;
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
	endtask

	// Model entries only for frames that are sent in full
	task automatic send_frame(input int sz, input int max_gap, input int n_send);
		int n;
		int gap;
		n = 1 << sz;
		for (int i = 0; i < n; i++) frame_buf[i] = random_sample();
		if (n_send == n) push_expected(sz);
		wait_for_ready();
		in_valid = 1'b1;
		in_sop   = 1'b1;
		in_size  = sz[2:0];
		in_data  = frame_buf[0][DATA_W-1:0];
		@(negedge clk);
		in_sop = 1'b0;
		for (int i = 1; i < n_send; i++) begin
			gap      = int'(next_random() % (max_gap + 1));
			in_valid = 1'b0;
			repeat (gap) @(negedge clk);
			in_valid = 1'b1;
			in_data  = frame_buf[i][DATA_W-1:0];
			@(negedge clk);
		end
		in_valid = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// Output collector
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid === 1'b1) begin
				if (exp_data.size() == 0) begin
					$display("ERROR at %0t ns: output word with no frame pending", $time);
					stop_on_failure();
				end else begin
					check_value(out_data, exp_data.pop_front(), "out_data");
					check_value(out_sop, exp_sop.pop_front(), "out_sop");
					check_value(out_eop, exp_eop.pop_front(), "out_eop");
					words_seen++;
					in_burst = !out_eop;
				end
			end else begin
				// Burst must run unbroken from sop to eop
				check_value(in_burst, 0, "out_valid low inside a burst");
			end
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR at %0t ns: watchdog expired, the DUT stopped producing output", $time);
		stop_on_failure();
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_sop   = 1'b0;
		in_size  = '0;
		in_data  = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value(sink_ready, 1, "sink_ready after reset");
		check_value(out_valid, 0, "out_valid after reset");
		check_value(state, IDLE, "state after reset");
		repeat (10) @(negedge clk);
		check_value(words_seen, 0, "output words before first frame");

		// Every size once, odd sizes with short gaps
		for (int sz = 1; sz <= LOG_N_MAX; sz++) begin
			send_frame(sz, (sz % 2) ? 3 : MAX_GAP, 1 << sz);
		end

		// Let the last result drain, then a frame that stalls
		while (exp_data.size() != 0) @(negedge clk);
		@(negedge clk);
		words_before = words_seen;
		send_frame(4, 2, 5);
		// Still sinking just short of the timeout, idle right after it
		repeat (SINK_TIMEOUT - 1) @(negedge clk);
		check_value(state, SINK, "state before sink timeout");
		repeat (3) @(negedge clk);
		check_value(state, IDLE, "state after sink timeout");
		wait_for_ready();
		check_value(words_seen, words_before, "output words from dropped frame");

		// Full frame right after the drop
		send_frame(5, 4, 32);

		// Back to back, random sizes, dense input
		for (int f = 0; f < NUM_B2B; f++) begin
			b2b_size = 1 + int'(next_random() % LOG_N_MAX);
			send_frame(b2b_size, 1, 1 << b2b_size);
		end

		while (exp_data.size() != 0) @(negedge clk);
		repeat (20) @(negedge clk);
		check_value(in_burst, 0, "burst still open at end");

		if (errors == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			stop_on_failure();
		end
	end

endmodule
